// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = fetchFrontendTb
FLIST     = fetchPredict.f
SIMARGS   = +verilator+error+limit+100

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP) $(SIMARGS))"; echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

// ==== fetchFrontend.sv ====
`timescale 1ns/10ps
`include "fetchPredict_config.svh"

module fetchFrontend (
    input  logic                            clk,
    input  logic                            rst,
    output logic                            wbCyc,
    output logic                            wbStb,
    output logic                            wbWe,
    output fetchPredictPkg::addrT           wbAdr,
    input  logic [2*`INSN_W-1:0]            wbDatI,
    input  logic                            wbAck,
    output fetchPredictPkg::fetchPacketT    fetchOut,
    output logic                            fetchValid,
    input  logic                            fetchReady,
    input  logic                            redirectValid,
    input  fetchPredictPkg::addrT           redirectPc,
    input  fetchPredictPkg::nlpUpdateT      backendUpdate
);
    import fetchPredictPkg::*;

    addrT        fetchPc;
    nlpInfoT     info0;
    nlpInfoT     info1;
    logic        reqValid;
    logic        reqReady;
    fetchPacketT pkt;
    logic        pktValid;
    logic        pktReady;
    nlpUpdateT   if3Update;
    logic        decodeRedirectValid;
    addrT        decodeRedirectPc;
    logic        flush;

    nlpTable nlpTable_i (
        .clk, .rst, .fetchPc, .info0, .info1, .if3Update, .backendUpdate
    );

    pcGen pcGen_i (
        .clk, .rst, .info0, .info1, .fetchPc, .reqValid, .reqReady,
        .redirectValid, .redirectPc, .decodeRedirectValid, .decodeRedirectPc
    );

    // Predictions ride along with the address of the same lookup
    imemFetch imemFetch_i (
        .clk, .rst, .reqValid, .reqReady, .reqPc(fetchPc),
        .reqPred0(info0), .reqPred1(info1),
        .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatI, .wbAck,
        .pkt, .pktValid, .pktReady, .flush
    );

    predecode predecode_i (
        .clk, .rst, .pkt, .pktValid, .pktReady, .fetchOut, .fetchValid, .fetchReady,
        .if3Update, .decodeRedirectValid, .decodeRedirectPc, .flush, .redirectValid
    );

endmodule

// ==== fetchFrontendProperties.sv ====
`timescale 1ns/10ps

module fetchFrontendProperties (
    input logic                         clk,
    input logic                         rst,
    input logic                         wbCyc,
    input logic                         wbStb,
    input logic                         wbWe,
    input logic                         wbAck,
    input fetchPredictPkg::fetchPacketT fetchOut,
    input logic                         fetchValid,
    input logic                         fetchReady,
    input logic                         redirectValid
);
    int failCount = 0;

    stbWithCyc: assert property (@(posedge clk) disable iff (rst) wbStb |-> wbCyc)
        else begin
            failCount++;
            $error("Wishbone strobe raised without cycle");
        end

    stbHeld: assert property (@(posedge clk) disable iff (rst) wbStb && !wbAck |=> wbStb)
        else begin
            failCount++;
            $error("Wishbone strobe dropped before ack");
        end

    noWrite: assert property (@(posedge clk) disable iff (rst) !wbWe)
        else begin
            failCount++;
            $error("Wishbone write enable set");
        end

    // A backend redirect may drop a held packet
    outStable: assert property (@(posedge clk) disable iff (rst)
        fetchValid && !fetchReady && !redirectValid |=> fetchValid && $stable(fetchOut))
        else begin
            failCount++;
            $error("Output packet changed while stalled");
        end

endmodule

// ==== fetchFrontendTb.sv ====
`timescale 1ns/10ps
`include "fetchPredict_config.svh"

module fetchFrontendTb;
    import fetchPredictPkg::*;

    // Packets accepted over all tests
    localparam int TOTAL_PKTS = 6 + 12 + 7 + 5 + 20 + 8;
    // One held packet checked per stream
    localparam int RUNS = 11;

    logic                  clk;
    logic                  rst;
    logic                  wbCyc;
    logic                  wbStb;
    logic                  wbWe;
    addrT                  wbAdr;
    logic [2*`INSN_W-1:0]  wbDatI;
    logic                  wbAck;
    fetchPacketT           fetchOut;
    logic                  fetchValid;
    logic                  fetchReady;
    logic                  redirectValid;
    addrT                  redirectPc;
    nlpUpdateT             backendUpdate;

    int          seed = 32'hb30a;
    int          errors = 0;
    int          checks = 0;
    int          testStart = 0;
    int          ackDelay;
    insnT        prog [addrT];
    addrT        jalOff [addrT];
    nlpEntryT    model [`NLP_ENTRIES];
    int          modelHead;
    addrT        modelPc;
    nlpUpdateT   beQueue [$];
    nlpUpdateT   stageUps [$];
    nlpUpdateT   trigUpdate;
    addrT        trigPc;
    addrT        armAdr;
    addrT        runPcs [$];
    addrT        firstRun [$];

    fetchFrontend fetchFrontend_i (
        .clk, .rst, .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatI, .wbAck,
        .fetchOut, .fetchValid, .fetchReady, .redirectValid, .redirectPc, .backendUpdate
    );

    bind fetchFrontend fetchFrontendProperties properties_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic insnT memWord(addrT a);
        if (prog.exists(a)) begin
            return prog[a];
        end
        // OP-IMM filler that is never a JAL
        return {a[24:0] ^ a[31:7], 7'b0010011};
    endfunction

    function automatic insnT jalInsn(addrT off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd0, 7'b1101111};
    endfunction

    // Program a JAL and remember the offset it was built with
    task automatic placeJal(addrT a, addrT off);
        prog[a] = jalInsn(off);
        jalOff[a] = off;
    endtask

    function automatic int findEntry(addrT a);
        for (int i = 0; i < `NLP_ENTRIES; i++) begin
            if (model[i].valid && model[i].pc == a) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic nlpInfoT lookup(addrT a);
        nlpInfoT info;
        int idx;
        info = '0;
        idx = findEntry(a);
        if (idx >= 0) begin
            info = '{valid: 1'b1, taken: model[idx].bimState[1],
                     bimState: model[idx].bimState, target: model[idx].targetAddr};
        end
        return info;
    endfunction

    function automatic bimStateT stepBim(bimStateT s, logic up);
        if (up) begin
            return (s == 2'b11) ? s : s + 2'd1;
        end
        return (s == 2'b00) ? s : s - 2'd1;
    endfunction

    // Expected packet for a fetch at pc plus the next pc and any training update
    function automatic fetchPacketT refPacket(addrT pc, output addrT nextPc,
                                              output nlpUpdateT upd);
        fetchPacketT p;
        addrT base;
        addrT slotPc;
        addrT jalTgt;
        nlpInfoT sp;
        insnT insn;
        logic found;
        base = {pc[31:3], 3'b000};
        found = 1'b0;
        upd = '0;
        p.pc = pc;
        p.insn0 = memWord(base);
        p.insn1 = memWord(base + 32'h4);
        p.pred0 = lookup({pc[31:2], 2'b00});
        p.pred1 = lookup(pc | 32'h4);
        p.slotValid[0] = !pc[2];
        p.slotValid[1] = !(p.slotValid[0] && p.pred0.valid && p.pred0.taken);
        if (p.pred0.valid && p.pred0.taken) begin
            nextPc = p.pred0.target;
        end else if (p.pred1.valid && p.pred1.taken && !pc[2]) begin
            nextPc = p.pred1.target;
        end else begin
            nextPc = base + 32'h8;
        end
        for (int s = 0; s < 2; s++) begin
            insn = (s == 0) ? p.insn0 : p.insn1;
            if (!found && p.slotValid[s] && insn[6:0] == 7'b1101111) begin
                found = 1'b1;
                slotPc = base + addrT'(4 * s);
                jalTgt = slotPc + jalOff[slotPc];
                sp = (s == 0) ? p.pred0 : p.pred1;
                if (!(sp.valid && sp.taken && sp.target == jalTgt)) begin
                    upd = '{valid: 1'b1, pc: slotPc, target: jalTgt,
                            bimState: 2'b01, shouldTake: 1'b1};
                    nextPc = jalTgt;
                    if (s == 0) begin
                        p.slotValid[1] = 1'b0;
                    end
                end
            end
        end
        return p;
    endfunction

    // Both ports of one cycle with the backend applied last
    task automatic applyUpdates(nlpUpdateT a, nlpUpdateT b);
        int hitA;
        int hitB;
        int missA;
        int missB;
        hitA = findEntry(a.pc);
        hitB = findEntry(b.pc);
        missA = (a.valid && hitA < 0) ? 1 : 0;
        missB = (b.valid && hitB < 0) ? 1 : 0;
        if (a.valid && hitA >= 0) begin
            model[hitA].targetAddr = a.target;
            model[hitA].bimState = stepBim(a.bimState, a.shouldTake);
        end else if (missA == 1) begin
            model[modelHead] = '{valid: 1'b1, pc: a.pc, targetAddr: a.target,
                                 bimState: a.bimState};
        end
        if (b.valid && hitB >= 0) begin
            model[hitB].targetAddr = b.target;
            model[hitB].bimState = stepBim(b.bimState, b.shouldTake);
        end else if (missB == 1) begin
            model[(modelHead + missA) % `NLP_ENTRIES] = '{valid: 1'b1, pc: b.pc,
                targetAddr: b.target, bimState: b.bimState};
        end
        modelHead = (modelHead + missA + missB) % `NLP_ENTRIES;
    endtask

    task automatic expectNext(output fetchPacketT exp);
        addrT nextPc;
        nlpUpdateT upd;
        exp = refPacket(modelPc, nextPc, upd);
        if (upd.valid && modelPc == trigPc) begin
            applyUpdates(upd, trigUpdate);
            trigPc = '1;
        end else begin
            applyUpdates(upd, '0);
        end
        modelPc = nextPc;
    endtask

    task automatic comparePacket(fetchPacketT got, fetchPacketT exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: packet pc %h slots %b taken %b%b, expected %h %b %b%b",
                     $time, got.pc, got.slotValid, got.pred0.taken, got.pred1.taken,
                     exp.pc, exp.slotValid, exp.pred0.taken, exp.pred1.taken);
        end
    endtask

    task automatic comparePc(addrT got, addrT exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: pc %h, expected %h", $time, got, exp);
        end
    endtask

    // Accept n packets and then check the one left in the output register
    task automatic runStream(int n, logic randomReady);
        fetchPacketT exp;
        int got;
        got = 0;
        runPcs.delete();
        @(posedge clk);
        #1;
        fetchReady = 1'b1;
        while (got < n) begin
            @(negedge clk);
            if (fetchValid && fetchReady) begin
                expectNext(exp);
                comparePacket(fetchOut, exp);
                runPcs.push_back(fetchOut.pc);
                got++;
            end
            @(posedge clk);
            #1;
            fetchReady = (got < n) && (!randomReady || ($random(seed) % 3 != 0));
        end
        do @(negedge clk); while (!fetchValid);
        expectNext(exp);
        comparePacket(fetchOut, exp);
    endtask

    // One redirect cycle per staged backend update
    task automatic redirectTo(addrT pc);
        int cycles;
        cycles = (stageUps.size() > 0) ? stageUps.size() : 1;
        @(posedge clk);
        while (stageUps.size() > 0) begin
            applyUpdates('0, stageUps[0]);
            beQueue.push_back(stageUps.pop_front());
        end
        #1;
        redirectValid = 1'b1;
        redirectPc = pc;
        repeat (cycles) @(posedge clk);
        #1;
        redirectValid = 1'b0;
        modelPc = pc;
    endtask

    task automatic endTest(string name);
        $display("%s: %0d errors", name, errors - testStart);
        testStart = errors;
    endtask

    // Wishbone slave with 0 to 3 wait cycles
    initial begin
        wbAck = 1'b0;
        wbDatI = '0;
        ackDelay = -1;
        forever begin
            @(negedge clk);
            if (wbCyc && wbStb && !wbAck && ackDelay < 0) begin
                ackDelay = $unsigned($random(seed)) % 4;
            end
            if (wbAck && wbAdr == armAdr) begin
                beQueue.push_back(trigUpdate);
                armAdr = '1;
            end
            @(posedge clk);
            #1;
            if (wbAck) begin
                wbAck = 1'b0;
            end else if (ackDelay == 0) begin
                wbAck = 1'b1;
                wbDatI = {memWord(wbAdr + 32'h4), memWord(wbAdr)};
                ackDelay = -1;
            end else if (ackDelay > 0) begin
                ackDelay--;
            end
        end
    end

    initial begin
        backendUpdate = '0;
        forever begin
            @(posedge clk);
            #1;
            if (beQueue.size() > 0) begin
                backendUpdate = beQueue.pop_front();
            end else begin
                backendUpdate = '0;
            end
        end
    end

    initial begin
        #((TOTAL_PKTS + RUNS) * 10 * 10);
        $display("Watchdog expired, the front end stopped delivering packets");
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        rst = 1'b1;
        fetchReady = 1'b0;
        redirectValid = 1'b0;
        redirectPc = '0;
        armAdr = '1;
        trigPc = '1;
        trigUpdate = '0;
        modelPc = `RESET_PC;
        modelHead = 0;
        for (int i = 0; i < `NLP_ENTRIES; i++) begin
            model[i] = '0;
        end
        // Loop body 0x1100..0x1114 closed by a JAL back to the top
        placeJal(32'h1114, 32'hFFFF_FFEC);
        placeJal(32'h1700, 32'h0000_0080);
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        runStream(6, 1'b0);
        endTest("straight line from reset");

        redirectTo(32'h1100);
        runStream(12, 1'b0);
        endTest("loop closed by JAL");

        stageUps.push_back('{valid: 1'b1, pc: 32'h1208, target: 32'h1240,
                             bimState: 2'b11, shouldTake: 1'b1});
        redirectTo(32'h1200);
        runStream(4, 1'b0);
        stageUps.push_back('{valid: 1'b1, pc: 32'h1208, target: 32'h1240,
                             bimState: 2'b11, shouldTake: 1'b0});
        stageUps.push_back('{valid: 1'b1, pc: 32'h1208, target: 32'h1240,
                             bimState: 2'b10, shouldTake: 1'b0});
        redirectTo(32'h1200);
        runStream(3, 1'b0);
        endTest("backend training");

        redirectTo(32'h1300);
        runStream(5, 1'b0);
        comparePc(runPcs[0], 32'h1300);
        endTest("backend redirect");

        redirectTo(32'h1100);
        runStream(10, 1'b0);
        firstRun = runPcs;
        redirectTo(32'h1100);
        runStream(10, 1'b1);
        for (int i = 0; i < 10; i++) begin
            comparePc(runPcs[i], firstRun[i]);
        end
        endTest("output back-pressure");

        for (int k = 0; k < 17; k++) begin
            stageUps.push_back('{valid: 1'b1,
                                 pc: (k == 0) ? 32'h1400 : 32'h1800 + addrT'(8 * k),
                                 target: 32'h1500, bimState: 2'b11, shouldTake: 1'b1});
        end
        redirectTo(32'h1400);
        runStream(2, 1'b0);
        // Backend insert lands in the same cycle as the JAL miss at 0x1700
        trigUpdate = '{valid: 1'b1, pc: 32'h1900, target: 32'h1A00,
                       bimState: 2'b11, shouldTake: 1'b1};
        trigPc = 32'h1700;
        armAdr = 32'h1700;
        redirectTo(32'h1700);
        runStream(3, 1'b0);
        redirectTo(32'h1900);
        runStream(2, 1'b0);
        redirectTo(32'h1700);
        runStream(1, 1'b0);
        endTest("table replacement");

        errors += fetchFrontend_i.properties_i.failCount;
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== fetchPredict.f ====
+incdir+.
fetchPredictPkg.sv
nlpTable.sv
pcGen.sv
imemFetch.sv
predecode.sv
fetchFrontend.sv
fetchFrontendProperties.sv
fetchFrontendTb.sv

// ==== fetchPredictPkg.sv ====
`include "fetchPredict_config.svh"

package fetchPredictPkg;

    typedef logic [`ADDR_W-1:0] addrT;
    typedef logic [`INSN_W-1:0] insnT;

    // Upper bit set means taken
    typedef logic [1:0] bimStateT;

    typedef struct packed {
        logic     valid;
        addrT     pc;
        addrT     targetAddr;
        bimStateT bimState;
    } nlpEntryT;

    // Prediction for one fetch slot
    typedef struct packed {
        logic     valid;
        logic     taken;
        bimStateT bimState;
        addrT     target;
    } nlpInfoT;

    typedef struct packed {
        logic     valid;
        addrT     pc;
        addrT     target;
        bimStateT bimState;
        logic     shouldTake;
    } nlpUpdateT;

    // Aligned instruction pair plus its predictions
    typedef struct packed {
        addrT       pc;
        insnT       insn0;
        insnT       insn1;
        logic [1:0] slotValid;
        nlpInfoT    pred0;
        nlpInfoT    pred1;
    } fetchPacketT;

endpackage

// ==== fetchPredict_config.svh ====
`ifndef FETCH_PREDICT_CONFIG_SVH
`define FETCH_PREDICT_CONFIG_SVH

// Byte address width
`define ADDR_W 32

// One instruction word
`define INSN_W 32

// Next-line predictor size
`define NLP_ENTRIES 16

// First fetch address after reset
`define RESET_PC 32'h0000_1000

`endif

// ==== imemFetch.sv ====
`timescale 1ns/10ps
`include "fetchPredict_config.svh"

module imemFetch (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            reqValid,
    output logic                            reqReady,
    input  fetchPredictPkg::addrT           reqPc,
    input  fetchPredictPkg::nlpInfoT        reqPred0,
    input  fetchPredictPkg::nlpInfoT        reqPred1,
    output logic                            wbCyc,
    output logic                            wbStb,
    output logic                            wbWe,
    output fetchPredictPkg::addrT           wbAdr,
    input  logic [2*`INSN_W-1:0]            wbDatI,
    input  logic                            wbAck,
    output fetchPredictPkg::fetchPacketT    pkt,
    output logic                            pktValid,
    input  logic                            pktReady,
    input  logic                            flush
);
    import fetchPredictPkg::*;

    logic    busy;
    logic    dropData;
    addrT    pcQ;
    nlpInfoT pred0Q;
    nlpInfoT pred1Q;

    // No new access while a packet is stuck or a flush is in progress
    assign reqReady = !busy && (!pktValid || pktReady) && !flush;

    assign wbCyc = busy;
    assign wbStb = busy;
    assign wbWe  = 1'b0;
    assign wbAdr = {pcQ[`ADDR_W-1:3], 3'b000};

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            dropData <= 1'b0;
            pktValid <= 1'b0;
        end else begin
            if (flush || (pktValid && pktReady)) begin
                pktValid <= 1'b0;
            end
            if (reqValid && reqReady) begin
                busy <= 1'b1;
            end else if (busy && wbAck) begin
                busy     <= 1'b0;
                dropData <= 1'b0;
                pktValid <= !(flush || dropData);
            end else if (busy && flush) begin
                // Let the bus cycle end but forget its data
                dropData <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reqValid && reqReady) begin
            pcQ    <= reqPc;
            pred0Q <= reqPred0;
            pred1Q <= reqPred1;
        end
        if (busy && wbAck) begin
            pkt.pc           <= pcQ;
            pkt.insn0        <= wbDatI[`INSN_W-1:0];
            pkt.insn1        <= wbDatI[2*`INSN_W-1:`INSN_W];
            pkt.slotValid[0] <= !pcQ[2];
            pkt.slotValid[1] <= !(!pcQ[2] && pred0Q.valid && pred0Q.taken);
            pkt.pred0        <= pred0Q;
            pkt.pred1        <= pred1Q;
        end
    end

endmodule

// ==== nlpTable.sv ====
`timescale 1ns/10ps
`include "fetchPredict_config.svh"

module nlpTable (
    input  logic                        clk,
    input  logic                        rst,
    input  fetchPredictPkg::addrT       fetchPc,
    output fetchPredictPkg::nlpInfoT    info0,
    output fetchPredictPkg::nlpInfoT    info1,
    input  fetchPredictPkg::nlpUpdateT  if3Update,
    input  fetchPredictPkg::nlpUpdateT  backendUpdate
);
    import fetchPredictPkg::*;

    localparam int IDX_W = $clog2(`NLP_ENTRIES);

    nlpEntryT           entries [`NLP_ENTRIES];
    logic [IDX_W-1:0]   head;
    addrT               lookPc0;
    addrT               lookPc1;
    logic               if3Hit;
    logic [IDX_W-1:0]   if3Idx;
    logic               beHit;
    logic [IDX_W-1:0]   beIdx;
    logic               if3Miss;
    logic               beMiss;
    logic [IDX_W-1:0]   beSlot;

    function automatic nlpInfoT makeInfo(nlpEntryT e);
        nlpInfoT info;
        info.valid    = 1'b1;
        info.taken    = e.bimState[1];
        info.bimState = e.bimState;
        info.target   = e.targetAddr;
        return info;
    endfunction

    // Saturating 2-bit counter step
    function automatic bimStateT nextBim(bimStateT s, logic up);
        if (up) begin
            return (s == 2'b11) ? 2'b11 : s + 2'd1;
        end
        return (s == 2'b00) ? 2'b00 : s - 2'd1;
    endfunction

    assign lookPc0 = fetchPc & ~addrT'(3);
    assign lookPc1 = fetchPc | addrT'(4);

    // Descending scan so the lowest matching index wins
    always_comb begin
        info0  = '0;
        info1  = '0;
        if3Hit = 1'b0;
        if3Idx = '0;
        beHit  = 1'b0;
        beIdx  = '0;
        for (int i = `NLP_ENTRIES - 1; i >= 0; i--) begin
            if (entries[i].valid && entries[i].pc == lookPc0) begin
                info0 = makeInfo(entries[i]);
            end
            if (entries[i].valid && entries[i].pc == lookPc1) begin
                info1 = makeInfo(entries[i]);
            end
            if (entries[i].valid && entries[i].pc == if3Update.pc) begin
                if3Hit = 1'b1;
                if3Idx = IDX_W'(i);
            end
            if (entries[i].valid && entries[i].pc == backendUpdate.pc) begin
                beHit = 1'b1;
                beIdx = IDX_W'(i);
            end
        end
    end

    assign if3Miss = if3Update.valid && !if3Hit;
    assign beMiss  = backendUpdate.valid && !beHit;
    // Backend insert goes one past the if3 insert
    assign beSlot  = head + IDX_W'(if3Miss);

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            for (int i = 0; i < `NLP_ENTRIES; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            if (if3Update.valid && if3Hit) begin
                entries[if3Idx].targetAddr <= if3Update.target;
                entries[if3Idx].bimState   <= nextBim(if3Update.bimState, if3Update.shouldTake);
            end else if (if3Miss) begin
                entries[head] <= '{valid: 1'b1, pc: if3Update.pc,
                                   targetAddr: if3Update.target, bimState: if3Update.bimState};
            end
            // Written last so the backend wins on a shared entry
            if (backendUpdate.valid && beHit) begin
                entries[beIdx].targetAddr <= backendUpdate.target;
                entries[beIdx].bimState   <= nextBim(backendUpdate.bimState,
                                                     backendUpdate.shouldTake);
            end else if (beMiss) begin
                entries[beSlot] <= '{valid: 1'b1, pc: backendUpdate.pc,
                                     targetAddr: backendUpdate.target,
                                     bimState: backendUpdate.bimState};
            end
            head <= head + IDX_W'(if3Miss) + IDX_W'(beMiss);
        end
    end

endmodule

// ==== pcGen.sv ====
`timescale 1ns/10ps
`include "fetchPredict_config.svh"

module pcGen (
    input  logic                        clk,
    input  logic                        rst,
    input  fetchPredictPkg::nlpInfoT    info0,
    input  fetchPredictPkg::nlpInfoT    info1,
    output fetchPredictPkg::addrT       fetchPc,
    output logic                        reqValid,
    input  logic                        reqReady,
    input  logic                        redirectValid,
    input  fetchPredictPkg::addrT       redirectPc,
    input  logic                        decodeRedirectValid,
    input  fetchPredictPkg::addrT       decodeRedirectPc
);
    import fetchPredictPkg::*;

    addrT seqPc;
    addrT predPc;

    assign seqPc = {fetchPc[`ADDR_W-1:3], 3'b000} + addrT'(8);

    // Slot 1 prediction only counts when slot 0 was fetched too
    always_comb begin
        if (info0.valid && info0.taken) begin
            predPc = info0.target;
        end else if (info1.valid && info1.taken && !fetchPc[2]) begin
            predPc = info1.target;
        end else begin
            predPc = seqPc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fetchPc  <= `RESET_PC;
            reqValid <= 1'b0;
        end else begin
            reqValid <= 1'b1;
            if (redirectValid) begin
                fetchPc <= redirectPc;
            end else if (decodeRedirectValid) begin
                fetchPc <= decodeRedirectPc;
            end else if (reqValid && reqReady) begin
                fetchPc <= predPc;
            end
        end
    end

endmodule

// ==== predecode.sv ====
`timescale 1ns/10ps
`include "fetchPredict_config.svh"

module predecode (
    input  logic                            clk,
    input  logic                            rst,
    input  fetchPredictPkg::fetchPacketT    pkt,
    input  logic                            pktValid,
    output logic                            pktReady,
    output fetchPredictPkg::fetchPacketT    fetchOut,
    output logic                            fetchValid,
    input  logic                            fetchReady,
    output fetchPredictPkg::nlpUpdateT      if3Update,
    output logic                            decodeRedirectValid,
    output fetchPredictPkg::addrT           decodeRedirectPc,
    output logic                            flush,
    input  logic                            redirectValid
);
    import fetchPredictPkg::*;

    localparam logic [6:0] OPC_JAL = 7'b1101111;

    logic [1:0]  isJal;
    logic        jalSlot;
    addrT        jalPc;
    addrT        jalTarget;
    nlpInfoT     jalPred;
    logic        misfetch;
    fetchPacketT fixedPkt;

    function automatic addrT jImm(insnT i);
        return {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
    endfunction

    assign pktReady = !fetchValid || fetchReady;

    assign isJal[0] = pkt.slotValid[0] && pkt.insn0[6:0] == OPC_JAL;
    assign isJal[1] = pkt.slotValid[1] && pkt.insn1[6:0] == OPC_JAL;
    // First JAL in program order
    assign jalSlot   = !isJal[0];
    assign jalPc     = {pkt.pc[`ADDR_W-1:3], jalSlot, 2'b00};
    assign jalPred   = jalSlot ? pkt.pred1 : pkt.pred0;
    assign jalTarget = jalPc + jImm(jalSlot ? pkt.insn1 : pkt.insn0);

    assign misfetch = pktValid && pktReady && !redirectValid && (|isJal)
                   && !(jalPred.valid && jalPred.taken && jalPred.target == jalTarget);

    always_comb begin
        fixedPkt = pkt;
        if (misfetch && !jalSlot) begin
            fixedPkt.slotValid[1] = 1'b0;
        end
    end

    assign if3Update = '{valid: misfetch, pc: jalPc, target: jalTarget,
                         bimState: 2'b01, shouldTake: 1'b1};
    assign decodeRedirectValid = misfetch;
    assign decodeRedirectPc    = jalTarget;
    assign flush               = misfetch || redirectValid;

    always_ff @(posedge clk) begin
        if (rst || redirectValid) begin
            fetchValid <= 1'b0;
        end else if (pktReady) begin
            fetchValid <= pktValid;
        end
    end

    always_ff @(posedge clk) begin
        if (pktValid && pktReady) begin
            fetchOut <= fixedPkt;
        end
    end

endmodule
